//--- logic/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

////////////////////////////////////////
// fetch front end build options
////////////////////////////////////////

// first fetch address out of reset
// boot ROM window of the core
`define FETCH_RESET_PC 32'h1c00_0000

// btb index bits, taken from pc[IDX+1:2]
// 6 gives 64 entries
`define BTB_IDX_W 6

// btb tag bits, taken right above the index
// aliasing beyond this is accepted, the predecoder
// catches it in IF2 anyway
`define BTB_TAG_W 8

// pc bits 1:0 are always zero for 32-bit words
// and never reach the btb

`endif

//--- logic/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // branch classes and opcodes
    ////////////////////////////////////////

    // branch class seen by btb and predecoder
    // direct_cond also covers plain b
    typedef enum logic [1:0] {
        br_none        = 2'b00,
        br_direct_cond = 2'b01,
        br_call        = 2'b10,
        br_jirl        = 2'b11
    } br_type_e;

    // major opcode, inst[31:26]
    typedef enum logic [5:0] {
        op_jirl = 6'h13,
        op_b    = 6'h14,
        op_bl   = 6'h15,
        op_beq  = 6'h16,
        op_bne  = 6'h17,
        op_blt  = 6'h18,
        op_bge  = 6'h19,
        op_bltu = 6'h1a,
        op_bgeu = 6'h1b
    } br_opcode_e;

    ////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////

    // predicted class and next pc, 34 bits
    typedef struct packed {
        br_type_e    br_type;
        logic [31:0] target;
    } br_pred_t;

    // IF1 -> IF2 register contents
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] pc_plus_4;
        br_pred_t    pred;
    } if2_slot_t;

    // redirect from IF2, also the btb training write
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        br_type_e    br_type;
        logic [31:0] target;
    } redirect_t;

endpackage

//--- logic/branch_target_buffer.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module branch_target_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic [31:0]          lookup_pc,
    input  fetch_pkg::redirect_t redirect,
    output fetch_pkg::br_pred_t  pred
);

    localparam int IDX_W   = `BTB_IDX_W;
    localparam int TAG_W   = `BTB_TAG_W;
    localparam int ENTRIES = 1 << IDX_W;
    // lowest tag bit, right above the index
    localparam int TAG_LO  = IDX_W + 2;

    // one table line, valid bit kept apart
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        fetch_pkg::br_type_e br_type;
        logic [31:0]         target;
    } btb_entry_t;

    btb_entry_t         entry_mem [ENTRIES];
    logic [ENTRIES-1:0] entry_valid;

    logic [IDX_W-1:0]   rd_idx;
    logic [TAG_W-1:0]   rd_tag;
    logic [IDX_W-1:0]   wr_idx;
    logic [TAG_W-1:0]   wr_tag;
    logic               wr_en;
    logic               hit;
    btb_entry_t         rd_entry;

    ////////////////////////////////////////
    // lookup, same cycle as fetch pc
    ////////////////////////////////////////

    // split fetch pc into index and tag
    assign rd_idx   = lookup_pc[TAG_LO-1:2];
    assign rd_tag   = lookup_pc[TAG_LO+TAG_W-1:TAG_LO];
    assign rd_entry = entry_mem[rd_idx];

    // valid line with matching tag
    assign hit = entry_valid[rd_idx] && (rd_entry.tag == rd_tag);

    // miss looks like a plain sequential fetch
    always_comb begin
        if (hit) begin
            pred.br_type = rd_entry.br_type;
            pred.target  = rd_entry.target;
        end else begin
            pred.br_type = fetch_pkg::br_none;
            pred.target  = lookup_pc + 32'd4;
        end
    end

    ////////////////////////////////////////
    // training from the IF2 redirect
    ////////////////////////////////////////

    // line addressed by the IF2 pc that flushed
    assign wr_idx = redirect.pc[TAG_LO-1:2];
    assign wr_tag = redirect.pc[TAG_LO+TAG_W-1:TAG_LO];

    // write lands on the same edge the redirect is taken
    assign wr_en = redirect.valid && !stall;

    // valid bits
    // br_none training drops the line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_idx] <= (redirect.br_type != fetch_pkg::br_none);
        end
    end

    // tag, class and target
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_mem[wr_idx].tag     <= wr_tag;
            entry_mem[wr_idx].br_type <= redirect.br_type;
            entry_mem[wr_idx].target  <= redirect.target;
        end
    end

endmodule

//--- logic/if2_predecoder.sv
`timescale 1ns/1ps

module if2_predecoder (
    input  fetch_pkg::if2_slot_t slot,
    input  logic [31:0]          inst,
    output fetch_pkg::redirect_t redirect
);

    fetch_pkg::br_opcode_e opcode;
    fetch_pkg::br_type_e   dec_type;

    logic        is_cond;
    logic        is_direct;
    logic        is_jirl;
    logic [31:0] offs16;
    logic [31:0] offs26;
    logic [31:0] calc_target;
    logic        type_ok;
    logic        target_ok;
    logic        pred_seq;
    logic        flush;
    logic [31:0] fixed_pc;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    assign opcode = fetch_pkg::br_opcode_e'(inst[31:26]);

    // class flags and branch type
    always_comb begin
        is_cond   = 1'b0;
        is_direct = 1'b0;
        is_jirl   = 1'b0;
        dec_type  = fetch_pkg::br_none;
        case (opcode)
            fetch_pkg::op_beq,
            fetch_pkg::op_bne,
            fetch_pkg::op_blt,
            fetch_pkg::op_bge,
            fetch_pkg::op_bltu,
            fetch_pkg::op_bgeu: begin
                is_cond  = 1'b1;
                dec_type = fetch_pkg::br_direct_cond;
            end
            // plain b shares the cond class
            fetch_pkg::op_b: begin
                is_direct = 1'b1;
                dec_type  = fetch_pkg::br_direct_cond;
            end
            fetch_pkg::op_bl: begin
                is_direct = 1'b1;
                dec_type  = fetch_pkg::br_call;
            end
            fetch_pkg::op_jirl: begin
                is_jirl  = 1'b1;
                dec_type = fetch_pkg::br_jirl;
            end
            default: begin
                dec_type = fetch_pkg::br_none;
            end
        endcase
    end

    // offs16 in 25:10, offs26 high part in 9:0
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    // pc-relative target, meaningless for jirl
    assign calc_target = slot.pc + (is_direct ? offs26 : offs16);

    ////////////////////////////////////////
    // prediction check
    ////////////////////////////////////////

    assign type_ok   = (dec_type == slot.pred.br_type);
    assign target_ok = (calc_target == slot.pred.target);
    assign pred_seq  = (slot.pred.target == slot.pc_plus_4);

    always_comb begin
        if (!slot.valid) begin
            flush = 1'b0;
        end else if (!type_ok) begin
            // wrong class always refetches
            flush = 1'b1;
        end else if (is_direct) begin
            flush = !target_ok;
        end else if (pred_seq || is_jirl) begin
            // fall-through guess, or jirl left to execute
            flush = 1'b0;
        end else begin
            flush = !target_ok;
        end
    end

    // corrected pc
    // cond on flush: backward taken, forward not taken
    always_comb begin
        if (is_direct) begin
            fixed_pc = calc_target;
        end else if (is_jirl) begin
            fixed_pc = slot.pred.target;
        end else if (flush) begin
            fixed_pc = (is_cond && (calc_target < slot.pc)) ? calc_target : slot.pc_plus_4;
        end else begin
            fixed_pc = slot.pred.target;
        end
    end

    // redirect doubles as the btb write
    always_comb begin
        redirect.valid   = flush;
        redirect.pc      = slot.pc;
        redirect.br_type = dec_type;
        redirect.target  = fixed_pc;
    end

endmodule

//--- logic/fetch_pc_gen.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_pc_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  fetch_pkg::br_pred_t  pred,
    input  fetch_pkg::redirect_t redirect,
    output logic [31:0]          fetch_pc,
    output fetch_pkg::if2_slot_t slot
);

    logic [31:0] pc_plus_4;
    logic [31:0] next_pc;
    logic        pred_taken;

    ////////////////////////////////////////
    // IF1 next pc
    ////////////////////////////////////////

    assign pc_plus_4 = fetch_pc + 32'd4;

    // btb miss already arrives as br_none
    assign pred_taken = (pred.br_type != fetch_pkg::br_none);

    // redirect wins over the btb guess
    always_comb begin
        if (redirect.valid) begin
            next_pc = redirect.target;
        end else if (pred_taken) begin
            next_pc = pred.target;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    // fetch pc, doubles as imem address
    // stall holds it, imem keeps the same word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= `FETCH_RESET_PC;
        end else if (!stall) begin
            fetch_pc <= next_pc;
        end
    end

    ////////////////////////////////////////
    // IF1 -> IF2 register
    ////////////////////////////////////////

    // valid follows the fetch, killed by redirect
    // the word fetched under a redirect is wrong path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot.valid <= 1'b0;
        end else if (!stall) begin
            slot.valid <= !redirect.valid;
        end
    end

    // pc and prediction ride along with the word
    // imem data itself arrives next cycle, not stored here
    always_ff @(posedge clk) begin
        if (!stall) begin
            slot.pc        <= fetch_pc;
            slot.pc_plus_4 <= pc_plus_4;
            slot.pred      <= pred;
        end
    end

endmodule

//--- logic/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic [31:0] imem_rdata,
    output logic [31:0] imem_addr,
    output logic        if2_valid,
    output logic [31:0] if2_pc,
    output logic [31:0] if2_ir,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    fetch_pkg::br_pred_t  pred;
    fetch_pkg::if2_slot_t slot;
    fetch_pkg::redirect_t redirect;

    ////////////////////////////////////////
    // IF1, pc and btb
    ////////////////////////////////////////

    // fetch pc drives imem directly
    fetch_pc_gen u_pc_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .pred     (pred),
        .redirect (redirect),
        .fetch_pc (imem_addr),
        .slot     (slot)
    );

    branch_target_buffer u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .lookup_pc (imem_addr),
        .redirect  (redirect),
        .pred      (pred)
    );

    ////////////////////////////////////////
    // IF2, predecode
    ////////////////////////////////////////

    if2_predecoder u_predec (
        .slot     (slot),
        .inst     (imem_rdata),
        .redirect (redirect)
    );

    // flat view for the decode stage
    assign if2_valid      = slot.valid;
    assign if2_pc         = slot.pc;
    assign if2_ir         = imem_rdata;
    assign redirect_valid = redirect.valid;
    assign redirect_pc    = redirect.target;

endmodule

//--- tb/fetch_frontend_sva.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_frontend_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic [31:0] imem_addr,
    input logic        if2_valid,
    input logic        redirect_valid
);

    ////////////////////////////////////////
    // reset
    ////////////////////////////////////////

    // sync reset parks fetch on the boot address
    reset_pc_a: assert property (@(posedge clk) !rst_n |=> imem_addr == `FETCH_RESET_PC)
        else $error("imem_addr is not the reset pc after reset");

    ////////////////////////////////////////
    // redirect and stall
    ////////////////////////////////////////

    // taken redirect kills the wrong-path word
    kill_a: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid && !stall |=> !if2_valid)
        else $error("if2_valid high right after a taken redirect");

    // frozen front end, imem address held
    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(imem_addr))
        else $error("imem_addr moved while stall was high");

    // only a live IF2 word can redirect
    redirect_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> if2_valid)
        else $error("redirect_valid without if2_valid");

endmodule

//--- tb/tb_fetch_frontend.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch_frontend;

    localparam logic [31:0] BASE = `FETCH_RESET_PC;
    // andi r0, r0, 0
    localparam logic [31:0] NOP_WORD = 32'h0340_0000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall;
    logic [31:0] imem_rdata = NOP_WORD;
    logic [31:0] imem_addr;
    logic        if2_valid;
    logic [31:0] if2_pc;
    logic [31:0] if2_ir;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // 1 KB of code from the reset pc
    logic [31:0]         imem [256];
    integer              seed = 32'hd912_4a90;
    // reference btb keyed by branch pc
    fetch_pkg::br_type_e ref_type [logic [31:0]];
    logic [31:0]         ref_tgt [logic [31:0]];
    logic [31:0]         exp_pc;
    // falling edges until the next valid IF2 word
    int                  exp_gap;

    fetch_frontend u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .imem_rdata     (imem_rdata),
        .imem_addr      (imem_addr),
        .if2_valid      (if2_valid),
        .if2_pc         (if2_pc),
        .if2_ir         (if2_ir),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    bind fetch_frontend fetch_frontend_sva u_sva (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .imem_addr      (imem_addr),
        .if2_valid      (if2_valid),
        .redirect_valid (redirect_valid)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // instruction memory
    ////////////////////////////////////////

    // outside the window reads as nop
    function automatic logic [31:0] read_word(logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - BASE;
        if (offs[31:10] == '0) begin
            return imem[offs[9:2]];
        end
        return NOP_WORD;
    endfunction

    // one-cycle read that holds its word under stall
    always @(posedge clk) begin
        if (!stall) begin
            imem_rdata <= read_word(imem_addr);
        end
    end

    task automatic write_word(logic [31:0] addr, logic [31:0] data);
        logic [31:0] offs;
        offs = addr - BASE;
        imem[offs[9:2]] = data;
    endtask

    task automatic clear_mem();
        foreach (imem[i]) begin
            imem[i] = NOP_WORD;
        end
    endtask

    // cond and jirl encoder with the word offset in bits 25:10
    function automatic logic [31:0] enc16(fetch_pkg::br_opcode_e op, logic [31:0] off);
        logic [31:0] w;
        w = off >> 2;
        return {op, w[15:0], 10'd0};
    endfunction

    // b and bl encoder with high offset bits in 9:0
    function automatic logic [31:0] enc26(fetch_pkg::br_opcode_e op, logic [31:0] off);
        logic [31:0] w;
        w = off >> 2;
        return {op, w[15:0], w[25:16]};
    endfunction

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s, got %h expected %h",
                                $time, what, got, exp));
        end
    endtask

    function automatic fetch_pkg::br_type_e class_of(logic [31:0] inst);
        case (inst[31:26])
            6'h13: return fetch_pkg::br_jirl;
            6'h15: return fetch_pkg::br_call;
            // b plus the six conditionals
            6'h14, 6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: return fetch_pkg::br_direct_cond;
            default: return fetch_pkg::br_none;
        endcase
    endfunction

    // expected flush and corrected pc for one IF2 word
    task automatic predict_slot(input logic [31:0] pc, input logic [31:0] inst,
                                output logic flush, output logic [31:0] fixed);
        fetch_pkg::br_type_e ptype;
        fetch_pkg::br_type_e dtype;
        logic [31:0]         ptgt;
        logic [31:0]         tgt;
        logic [25:0]         w26;
        logic                long_jump;
        ptype = fetch_pkg::br_none;
        ptgt  = pc + 32'd4;
        if (ref_type.exists(pc)) begin
            ptype = ref_type[pc];
            ptgt  = ref_tgt[pc];
        end
        dtype     = class_of(inst);
        long_jump = (inst[31:26] == 6'h14) || (inst[31:26] == 6'h15);
        w26       = {inst[9:0], inst[25:10]};
        if (long_jump) begin
            tgt = pc + {{6{w26[25]}}, w26} * 4;
        end else begin
            tgt = pc + {{16{w26[15]}}, w26[15:0]} * 4;
        end
        if (dtype != ptype) begin
            flush = 1'b1;
        end else if (!long_jump && (ptgt == pc + 32'd4 || dtype == fetch_pkg::br_jirl)) begin
            flush = 1'b0;
        end else begin
            flush = (tgt != ptgt);
        end
        if (long_jump) begin
            fixed = tgt;
        end else if (dtype == fetch_pkg::br_jirl || !flush) begin
            fixed = ptgt;
        end else if (dtype == fetch_pkg::br_direct_cond && tgt < pc) begin
            // backward cond counts as taken
            fixed = tgt;
        end else begin
            fixed = pc + 32'd4;
        end
    endtask

    task automatic check_slot();
        logic [31:0] inst;
        logic        flush;
        logic [31:0] fixed;
        inst = read_word(if2_pc);
        check(if2_pc, exp_pc, "if2_pc out of fetch order");
        check(if2_ir, inst, "if2_ir");
        predict_slot(if2_pc, inst, flush, fixed);
        check(32'(redirect_valid), 32'(flush), "redirect_valid");
        if (flush) begin
            check(redirect_pc, fixed, "redirect_pc");
            // btb line follows the redirect and a non-branch drops it
            if (class_of(inst) == fetch_pkg::br_none) begin
                ref_type.delete(if2_pc);
            end else begin
                ref_type[if2_pc] = class_of(inst);
                ref_tgt[if2_pc]  = fixed;
            end
        end
        exp_pc  = fixed;
        // a redirect leaves exactly one bubble
        exp_gap = flush ? 2 : 1;
    endtask

    // next valid IF2 word checked against the model
    task automatic step_valid();
        int n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!if2_valid && n < 50);
        if (!if2_valid) begin
            abort_run("timed out after 50 cycles waiting for if2_valid");
        end
        check(32'(n), 32'(exp_gap), "cycles to next valid IF2 word");
        check_slot();
    endtask

    task automatic seek_pc(logic [31:0] pc);
        int n = 0;
        do begin
            step_valid();
            n++;
        end while (if2_pc != pc && n < 50);
        if (if2_pc != pc) begin
            abort_run($sformatf("timed out waiting for if2_pc to reach %h", pc));
        end
    endtask

    // empty btb and memory for each test
    task automatic apply_reset();
        rst_n = 1'b0;
        stall = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        clear_mem();
        ref_type.delete();
        ref_tgt.delete();
        exp_pc  = BASE;
        exp_gap = 1;
        check(imem_addr, BASE, "imem_addr after reset");
        check(32'(if2_valid), 32'd0, "if2_valid after reset");
        check(32'(redirect_valid), 32'd0, "redirect_valid after reset");
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic sequential_fetch();
        int i;
        apply_reset();
        for (i = 0; i < 8; i++) begin
            step_valid();
            check(if2_pc, BASE + 32'(4 * i), "sequential if2_pc");
        end
    endtask

    // b or bl forward with a b back to close the loop
    task automatic direct_jump_training(fetch_pkg::br_opcode_e op);
        logic [31:0] off;
        logic [31:0] br_pc;
        off   = 32'(4 * (2 + ($random(seed) & 31)));
        br_pc = BASE + 32'h8;
        apply_reset();
        write_word(br_pc, enc26(op, off));
        write_word(br_pc + off, enc26(fetch_pkg::op_b, -off));
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd1, "first pass redirect");
        check(redirect_pc, br_pc + off, "first pass target");
        step_valid();
        check(if2_pc, br_pc + off, "fetch after redirect");
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd0, "trained pass redirect");
    endtask

    task automatic conditional_direction();
        logic [31:0] br_pc;
        br_pc = BASE + 32'h20;
        apply_reset();
        write_word(br_pc, enc16(fetch_pkg::op_blt, -32'd16));
        seek_pc(br_pc);
        check(redirect_pc, br_pc - 32'd16, "backward cond target");
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd0, "backward cond once trained");
        // forward cond falls through
        br_pc = BASE + 32'h8;
        apply_reset();
        write_word(br_pc, enc16(fetch_pkg::op_bne, 32'h20));
        write_word(br_pc + 32'h8, enc26(fetch_pkg::op_b, -32'd8));
        seek_pc(br_pc);
        check(redirect_pc, br_pc + 32'd4, "forward cond corrected pc");
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd0, "forward cond once trained");
        step_valid();
        check(if2_pc, br_pc + 32'd4, "forward cond next pc");
    endtask

    task automatic jirl_type_fix();
        logic [31:0] jr_pc;
        jr_pc = BASE + 32'hc;
        apply_reset();
        write_word(jr_pc, enc16(fetch_pkg::op_jirl, 32'h40));
        write_word(jr_pc + 32'h8, enc26(fetch_pkg::op_b, -32'd8));
        seek_pc(jr_pc);
        check(32'(redirect_valid), 32'd1, "jirl first pass redirect");
        check(redirect_pc, jr_pc + 32'd4, "jirl keeps predicted pc");
        seek_pc(jr_pc);
        check(32'(redirect_valid), 32'd0, "jirl second pass redirect");
    endtask

    task automatic stall_hold();
        logic [31:0] held_addr;
        int          i;
        apply_reset();
        write_word(BASE + 32'h8, enc26(fetch_pkg::op_b, 32'h30));
        seek_pc(BASE + 32'h8);
        // btb miss so IF1 sits on the next word
        held_addr = BASE + 32'hc;
        check(imem_addr, held_addr, "imem_addr before stall");
        stall     = 1'b1;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            check(imem_addr, held_addr, "imem_addr under stall");
            check(if2_pc, BASE + 32'h8, "if2_pc under stall");
            check(32'(if2_valid), 32'd1, "if2_valid under stall");
            check(32'(redirect_valid), 32'd1, "redirect held under stall");
        end
        stall = 1'b0;
        step_valid();
        check(if2_pc, BASE + 32'h38, "redirect taken after stall");
    endtask

    // trained b overwritten by a nop must drop its btb line
    task automatic stale_entry_drop();
        logic [31:0] br_pc;
        br_pc = BASE + 32'h10;
        apply_reset();
        write_word(br_pc, enc26(fetch_pkg::op_b, 32'h30));
        write_word(BASE + 32'h40, enc26(fetch_pkg::op_b, -32'h40));
        seek_pc(br_pc);
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd0, "trained b");
        seek_pc(BASE + 32'h40);
        // IF1 is back at the reset pc here
        write_word(br_pc, NOP_WORD);
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd1, "stale hit redirect");
        check(redirect_pc, br_pc + 32'd4, "stale hit corrected pc");
        seek_pc(br_pc);
        check(32'(redirect_valid), 32'd0, "entry dropped");
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        clear_mem();
        sequential_fetch();
        direct_jump_training(fetch_pkg::op_b);
        direct_jump_training(fetch_pkg::op_bl);
        conditional_direction();
        jirl_type_fix();
        stall_hold();
        stale_entry_drop();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- fetch_frontend.f
+incdir+logic
logic/fetch_pkg.sv
logic/branch_target_buffer.sv
logic/if2_predecoder.sv
logic/fetch_pc_gen.sv
logic/fetch_frontend.sv
tb/fetch_frontend_sva.sv
tb/tb_fetch_frontend.sv

//--- Makefile
TOP = tb_fetch_frontend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f fetch_frontend.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f fetch_frontend.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
